//--- bus_soc.f
+incdir+include
logic/bus_soc_pkg.sv
logic/periph_if.sv
logic/bus_decoder.sv
logic/bus_ram.sv
logic/mtimer.sv
logic/plic_lite.sv
logic/bus_soc_top.sv
tb/bus_soc_chk.sv
tb/bus_soc_tb.sv

//--- include/bus_soc_macros.svh
`ifndef BUS_SOC_MACROS_SVH
`define BUS_SOC_MACROS_SVH

// on-chip ram, 32-bit words
`define RAM_BASE            64'h0000_0000_8000_0000
`define RAM_WORDS           1024
`define RAM_BYTES           (`RAM_WORDS * 4)

// machine timer registers
`define MTIMECMP_ADDR       64'h0000_0000_0200_4000
`define MTIME_ADDR          64'h0000_0000_0200_BFF8
`define MTIMECMP_RESET      64'h0000_0000_8000_0000

// platform interrupt controller, offsets are from PLIC_BASE
`define PLIC_BASE           64'h0000_0000_0C00_0000
`define PLIC_SIZE           64'h0000_0000_0400_0000
`define PLIC_SOURCES        6
`define PLIC_CONTEXTS       2
`define PLIC_PENDING_OFS    32'h0000_1000
`define PLIC_ENABLE_OFS     32'h0000_2000
`define PLIC_ENABLE_STRIDE  32'h0000_0080
`define PLIC_THRESHOLD_OFS  32'h0020_0000
`define PLIC_CLAIM_OFS      32'h0020_0004
`define PLIC_CTX_STRIDE     32'h0000_1000
`define PLIC_PRIO_BITS      3

`endif

//--- logic/bus_decoder.sv
`timescale 1ns/1ps
`include "bus_soc_macros.svh"

module bus_decoder (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  bus_soc_pkg::bus_addr_t bus_address,
    input  bus_soc_pkg::bus_data_t bus_write_data,
    input  bus_soc_pkg::ls_type_e  bus_ls_type,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    output bus_soc_pkg::bus_data_t bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    periph_if.initiator            ram,
    periph_if.initiator            timer,
    periph_if.initiator            plic
);

    logic hit_ram, hit_timer, hit_plic;
    bus_soc_pkg::bus_addr_t ofs_next;

    logic sel_ram, sel_timer, sel_plic;
    logic is_write;
    logic issue;      // request latched, req goes out next edge
    logic req_q;
    logic none_ack;   // local completion for unmapped addresses
    logic ack_any;

    bus_soc_pkg::bus_addr_t ofs_q;
    bus_soc_pkg::bus_data_t wdata_q;
    bus_soc_pkg::ls_type_e  ls_q;

    // address map, decoded once on the enable edge
    assign hit_ram   = (bus_address >= `RAM_BASE) && (bus_address < `RAM_BASE + `RAM_BYTES);
    assign hit_timer = (bus_address == `MTIMECMP_ADDR) || (bus_address == `MTIME_ADDR);
    assign hit_plic  = (bus_address >= `PLIC_BASE) && (bus_address < `PLIC_BASE + `PLIC_SIZE);

    always_comb begin
        if (hit_ram)        ofs_next = bus_address - `RAM_BASE;
        else if (hit_timer) ofs_next = bus_address - `MTIMECMP_ADDR;
        else if (hit_plic)  ofs_next = bus_address - `PLIC_BASE;
        else                ofs_next = '0;
    end

    assign ack_any = ram.ack | timer.ack | plic.ack | none_ack;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            sel_ram   <= 1'b0;
            sel_timer <= 1'b0;
            sel_plic  <= 1'b0;
            is_write  <= 1'b0;
            issue     <= 1'b0;
            req_q     <= 1'b0;
            none_ack  <= 1'b0;
        end else begin
            issue    <= bus_read_enable | bus_write_enable;
            req_q    <= issue;
            none_ack <= req_q & ~(sel_ram | sel_timer | sel_plic); // mimics a one-edge target
            if (bus_read_enable)  bus_read_done  <= 1'b0;
            if (bus_write_enable) bus_write_done <= 1'b0;
            if (bus_read_enable || bus_write_enable) begin
                sel_ram   <= hit_ram;
                sel_timer <= hit_timer;
                sel_plic  <= hit_plic;
                is_write  <= bus_write_enable;
            end
            if (ack_any) begin
                bus_read_done  <= 1'b1;
                bus_write_done <= 1'b1;
            end
        end
    end

    // request payload, held until the next enable
    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable || bus_write_enable) begin
            ofs_q   <= ofs_next;
            wdata_q <= bus_write_data;
            ls_q    <= bus_ls_type;
        end
        if (ack_any && !is_write) begin
            if (sel_ram)        bus_read_data <= ram.rdata;
            else if (sel_timer) bus_read_data <= timer.rdata;
            else if (sel_plic)  bus_read_data <= plic.rdata;
            else                bus_read_data <= '0; // unmapped reads zero
        end
    end

    assign ram.req     = req_q & sel_ram;
    assign ram.we      = is_write;
    assign ram.ofs     = ofs_q;
    assign ram.wdata   = wdata_q;
    assign ram.ls_type = ls_q;

    assign timer.req     = req_q & sel_timer;
    assign timer.we      = is_write;
    assign timer.ofs     = ofs_q;
    assign timer.wdata   = wdata_q;
    assign timer.ls_type = ls_q;

    assign plic.req     = req_q & sel_plic;
    assign plic.we      = is_write;
    assign plic.ofs     = ofs_q;
    assign plic.wdata   = wdata_q;
    assign plic.ls_type = ls_q;

endmodule

//--- logic/bus_ram.sv
`timescale 1ns/1ps
`include "bus_soc_macros.svh"

module bus_ram (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    periph_if.target  port
);

    localparam int IW = $clog2(`RAM_WORDS);

    bus_soc_pkg::ram_word_t mem [`RAM_WORDS];

    logic                   step;      // second beat of a double
    logic [IW+1:0]          aofs;      // offset aligned to access size
    logic [1:0]             lane;
    logic [IW-1:0]          idx;
    logic                   is_double;
    logic                   beat;
    logic [3:0]             be;
    bus_soc_pkg::ram_word_t wword;
    bus_soc_pkg::ram_word_t shifted;
    bus_soc_pkg::ram_word_t lo_word;
    bus_soc_pkg::bus_data_t ld_ext;

    assign is_double = (port.ls_type == bus_soc_pkg::LS_D);
    assign beat      = port.req | step;

    always_comb begin
        case (port.ls_type)
            bus_soc_pkg::LS_B, bus_soc_pkg::LS_BU: aofs = port.ofs[IW+1:0];
            bus_soc_pkg::LS_H, bus_soc_pkg::LS_HU: aofs = {port.ofs[IW+1:1], 1'b0};
            bus_soc_pkg::LS_D:                     aofs = {port.ofs[IW+1:3], 3'b000};
            default:                               aofs = {port.ofs[IW+1:2], 2'b00};
        endcase
    end

    assign lane = aofs[1:0];
    assign idx  = aofs[IW+1:2] | IW'(step); // doubles are 8-aligned, bit 0 is free

    // store lanes
    always_comb begin
        be    = 4'b1111;
        wword = step ? port.wdata[63:32] : port.wdata[31:0];
        case (port.ls_type)
            bus_soc_pkg::LS_B: begin
                be    = 4'b0001 << lane;
                wword = {4{port.wdata[7:0]}};
            end
            bus_soc_pkg::LS_H: begin
                be    = 4'b0011 << lane;
                wword = {2{port.wdata[15:0]}};
            end
            default: be = 4'b1111;
        endcase
    end

    // load lane select and extension
    assign shifted = mem[idx] >> {lane, 3'b000};

    always_comb begin
        case (port.ls_type)
            bus_soc_pkg::LS_B:  ld_ext = {{56{shifted[7]}}, shifted[7:0]};
            bus_soc_pkg::LS_H:  ld_ext = {{48{shifted[15]}}, shifted[15:0]};
            bus_soc_pkg::LS_BU: ld_ext = {56'd0, shifted[7:0]};
            bus_soc_pkg::LS_HU: ld_ext = {48'd0, shifted[15:0]};
            bus_soc_pkg::LS_WU: ld_ext = {32'd0, shifted};
            default:            ld_ext = {{32{shifted[31]}}, shifted};
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step     <= 1'b0;
            port.ack <= 1'b0;
        end else begin
            port.ack <= 1'b0;
            if (step) begin
                step     <= 1'b0;
                port.ack <= 1'b1;
            end else if (port.req) begin
                if (is_double) step <= 1'b1; // high word next edge
                else port.ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat && port.we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem[idx][8*i +: 8] <= wword[8*i +: 8];
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat && !port.we) begin
            if (!is_double) port.rdata <= ld_ext;
            else if (step)  port.rdata <= {mem[idx], lo_word};
            else            lo_word    <= mem[idx];
        end
    end

endmodule

//--- logic/bus_soc_pkg.sv
package bus_soc_pkg;

    // full-width address and data of the master port
    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;

    // one storage word of the ram
    typedef logic [31:0] ram_word_t;

    // load/store access type, stores use the first four codes
    typedef enum logic [2:0] {
        LS_B  = 3'b000, // byte, sign-extended on load
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011, // double, two ram beats
        LS_BU = 3'b100, // unsigned loads
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

endpackage

//--- logic/bus_soc_top.sv
`timescale 1ns/1ps

module bus_soc_top (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  bus_soc_pkg::bus_addr_t bus_address,
    input  bus_soc_pkg::bus_data_t bus_write_data,
    input  bus_soc_pkg::ls_type_e  bus_ls_type,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    output bus_soc_pkg::bus_data_t bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    input  logic                   irq_src,    // external source id 1
    output logic                   meip,
    output logic                   seip,
    output logic                   mtip
);

    periph_if ram_bus ();
    periph_if timer_bus ();
    periph_if plic_bus ();

    bus_decoder bus_decoder_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram              (ram_bus.initiator),
        .timer            (timer_bus.initiator),
        .plic             (plic_bus.initiator)
    );

    bus_ram bus_ram_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .port     (ram_bus.target)
    );

    mtimer mtimer_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .port     (timer_bus.target),
        .mtip     (mtip)
    );

    plic_lite plic_lite_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .port     (plic_bus.target),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

//--- logic/mtimer.sv
`timescale 1ns/1ps
`include "bus_soc_macros.svh"

module mtimer (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    periph_if.target port,
    output logic     mtip
);

    // offsets inside the timer region, which starts at mtimecmp
    localparam bus_soc_pkg::bus_addr_t MTIMECMP_OFS = '0;
    localparam bus_soc_pkg::bus_addr_t MTIME_OFS    = `MTIME_ADDR - `MTIMECMP_ADDR;

    bus_soc_pkg::bus_data_t mtime;
    bus_soc_pkg::bus_data_t mtimecmp;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= `MTIMECMP_RESET;
            port.ack <= 1'b0;
        end else begin
            mtime    <= mtime + 64'd1; // free running
            port.ack <= port.req;
            // mtime itself is read-only here
            if (port.req && port.we && port.ofs == MTIMECMP_OFS) begin
                mtimecmp <= port.wdata;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (port.req) begin
            if (port.ofs == MTIME_OFS)         port.rdata <= mtime;
            else if (port.ofs == MTIMECMP_OFS) port.rdata <= mtimecmp;
            else                               port.rdata <= '0;
        end
    end

    assign mtip = (mtime >= mtimecmp);

endmodule

//--- logic/periph_if.sv
`timescale 1ns/1ps

// request/ack link from the decoder to one target
interface periph_if;
    logic                  req;     // one-cycle request pulse
    logic                  we;
    bus_soc_pkg::bus_addr_t ofs;     // byte offset inside the region
    bus_soc_pkg::bus_data_t wdata;
    bus_soc_pkg::ls_type_e  ls_type;
    bus_soc_pkg::bus_data_t rdata;   // valid in the ack cycle
    logic                  ack;     // one-cycle completion pulse

    modport initiator (
        output req, we, ofs, wdata, ls_type,
        input  rdata, ack
    );

    modport target (
        input  req, we, ofs, wdata, ls_type,
        output rdata, ack
    );

endinterface

//--- logic/plic_lite.sv
`timescale 1ns/1ps
`include "bus_soc_macros.svh"

module plic_lite (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    periph_if.target port,
    input  logic     irq_src,
    output logic     meip,
    output logic     seip
);

    localparam int IDW = $clog2(`PLIC_SOURCES);
    localparam int NCTX = `PLIC_CONTEXTS;

    logic [`PLIC_PRIO_BITS-1:0] prio      [`PLIC_SOURCES];
    logic [31:0]                pending;
    logic [31:0]                enable    [NCTX];
    logic [`PLIC_PRIO_BITS-1:0] threshold [NCTX];
    logic                       irq_q;

    logic                       prio_hit;
    logic [IDW-1:0]             prio_id;
    logic                       pend_hit;
    logic [NCTX-1:0]            en_hit, thr_hit, clm_hit;
    logic [NCTX-1:0]            claim;    // source 1 claimable per context
    bus_soc_pkg::bus_data_t     rd_next;

    assign prio_id = port.ofs[IDW+1:2]; // 4 bytes per id

    always_comb begin
        prio_hit = port.ofs < bus_soc_pkg::bus_addr_t'(`PLIC_SOURCES * 4);
        pend_hit = port.ofs == `PLIC_PENDING_OFS;
        for (int c = 0; c < NCTX; c++) begin
            en_hit[c]  = port.ofs == `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE;
            thr_hit[c] = port.ofs == `PLIC_THRESHOLD_OFS + c * `PLIC_CTX_STRIDE;
            clm_hit[c] = port.ofs == `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE;
            claim[c]   = pending[1] & enable[c][1];
        end
    end

    always_comb begin
        rd_next = '0; // unknown offsets read zero
        if (prio_hit) rd_next = bus_soc_pkg::bus_data_t'(prio[prio_id]);
        if (pend_hit) rd_next = bus_soc_pkg::bus_data_t'(pending);
        for (int c = 0; c < NCTX; c++) begin
            if (en_hit[c])  rd_next = bus_soc_pkg::bus_data_t'(enable[c]);
            if (thr_hit[c]) rd_next = bus_soc_pkg::bus_data_t'(threshold[c]);
            if (clm_hit[c]) rd_next = bus_soc_pkg::bus_data_t'(claim[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < `PLIC_SOURCES; i++) prio[i] <= '0;
            for (int c = 0; c < NCTX; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
            pending  <= '0;
            irq_q    <= 1'b0;
            port.ack <= 1'b0;
        end else begin
            port.ack <= port.req;
            irq_q    <= irq_src;
            if (port.req && port.we) begin
                if (prio_hit) prio[prio_id] <= port.wdata[`PLIC_PRIO_BITS-1:0];
                for (int c = 0; c < NCTX; c++) begin
                    if (en_hit[c])  enable[c]    <= port.wdata[31:0];
                    if (thr_hit[c]) threshold[c] <= port.wdata[`PLIC_PRIO_BITS-1:0];
                end
            end
            // a successful claim read retires source 1
            if (port.req && !port.we && |(clm_hit & claim)) pending[1] <= 1'b0;
            if (irq_src && !irq_q) pending[1] <= 1'b1; // new edge wins over claim
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (port.req) port.rdata <= rd_next;
    end

    assign meip = claim[0];
    assign seip = claim[1];

endmodule

//--- tb/bus_soc_chk.sv
`timescale 1ns/1ps

module bus_soc_chk (
    input logic CLOCK_50,
    input logic KEY0,
    input logic bus_read_enable,
    input logic bus_write_enable,
    input logic bus_read_done,
    input logic bus_write_done,
    input logic irq_src,
    input logic meip,
    input logic seip,
    input logic mtip,
    input logic pend1     // pending bit of source 1
);

    int fails = 0;        // failed assertions so far

    // one request at a time, only from idle
    rd_en_idle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable |-> bus_read_done)
        else begin $error("read enable while read done is low"); fails++; end
    wr_en_idle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable |-> bus_write_done)
        else begin $error("write enable while write done is low"); fails++; end

    // doubles are the slowest access
    rd_done_back: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_read_done) |-> ##[1:4] bus_read_done)
        else begin $error("read done did not return within 4 cycles"); fails++; end
    wr_done_back: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_write_done) |-> ##[1:4] bus_write_done)
        else begin $error("write done did not return within 4 cycles"); fails++; end

    reset_state: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> bus_read_done && bus_write_done && !meip && !seip && !mtip)
        else begin $error("done or interrupt outputs wrong after reset"); fails++; end

    // source 1 latches only on a rising edge
    irq_edge: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(pend1) |-> $past(irq_src) && !$past(irq_src, 2))
        else begin $error("pending source 1 set without a rising irq_src edge"); fails++; end

endmodule

bind bus_soc_top bus_soc_chk bus_soc_chk_inst (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_done    (bus_read_done),
    .bus_write_done   (bus_write_done),
    .irq_src          (irq_src),
    .meip             (meip),
    .seip             (seip),
    .mtip             (mtip),
    .pend1            (plic_lite_inst.pending[1])
);

//--- tb/bus_soc_tb.sv
`timescale 1ns/1ps
`include "bus_soc_macros.svh"

module bus_soc_tb;

    localparam int RAM_OPS    = 300;
    localparam int WIN_BYTES  = 128;              // ram window under random test
    localparam int NUM_OPS    = RAM_OPS + 80;     // window fill plus directed accesses
    localparam int MAX_CYCLES = NUM_OPS * 6 + 200;

    logic                   CLOCK_50;
    logic                   KEY0;
    bus_soc_pkg::bus_addr_t bus_address;
    bus_soc_pkg::bus_data_t bus_write_data;
    bus_soc_pkg::bus_data_t bus_read_data;
    bus_soc_pkg::ls_type_e  bus_ls_type;
    logic                   bus_read_enable;
    logic                   bus_write_enable;
    logic                   bus_read_done;
    logic                   bus_write_done;
    logic                   irq_src;
    logic                   meip;
    logic                   seip;
    logic                   mtip;

    logic [31:0]            rng;
    logic [7:0]             ram_model [WIN_BYTES];  // byte image of the window
    bus_soc_pkg::bus_data_t model_mtimecmp;
    logic [31:0]            model_pending;
    logic [31:0]            model_enable [2];
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles = 0;

    bus_soc_top bus_soc_top_inst (.*);

    initial CLOCK_50 = 1'b0;
    always #4 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng ^ (rng >> 16); // fold high bits into weak low bits
    endfunction

    function automatic int unsigned access_bytes(input bus_soc_pkg::ls_type_e t);
        case (t)
            bus_soc_pkg::LS_B, bus_soc_pkg::LS_BU: return 1;
            bus_soc_pkg::LS_H, bus_soc_pkg::LS_HU: return 2;
            bus_soc_pkg::LS_D:                     return 8;
            default:                               return 4;
        endcase
    endfunction

    function automatic void store_model(input int unsigned ofs, input bus_soc_pkg::bus_data_t d,
                                        input bus_soc_pkg::ls_type_e t);
        int unsigned n;
        int unsigned base;
        n = access_bytes(t);
        base = ofs - ofs % n;  // aligned down to access size
        for (int i = 0; i < n; i++) ram_model[base + i] = d[8*i +: 8];
    endfunction

    function automatic bus_soc_pkg::bus_data_t model_load(input int unsigned ofs,
                                                          input bus_soc_pkg::ls_type_e t);
        int unsigned            n;
        int unsigned            base;
        bus_soc_pkg::bus_data_t v;
        n = access_bytes(t);
        base = ofs - ofs % n;
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = ram_model[base + i]; // little endian
        case (t)
            bus_soc_pkg::LS_B: v = {{56{v[7]}}, v[7:0]};
            bus_soc_pkg::LS_H: v = {{48{v[15]}}, v[15:0]};
            bus_soc_pkg::LS_W: v = {{32{v[31]}}, v[31:0]};
            default: ;         // unsigned loads and doubles are zero-filled already
        endcase
        return v;
    endfunction

    task automatic check(input string name, input bus_soc_pkg::bus_data_t exp,
                         input bus_soc_pkg::bus_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one master request, waits for its done flag
    task automatic bus_access(input logic we, input bus_soc_pkg::bus_addr_t addr,
                              input bus_soc_pkg::bus_data_t wdata,
                              input bus_soc_pkg::ls_type_e t,
                              output bus_soc_pkg::bus_data_t rdata);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_data   = wdata;
        bus_ls_type      = t;
        bus_write_enable = we;
        bus_read_enable  = !we;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        while (!(we ? bus_write_done : bus_read_done)) @(negedge CLOCK_50);
        rdata = bus_read_data;
    endtask

    initial begin
        bus_soc_pkg::bus_data_t rd;
        bus_soc_pkg::bus_data_t wd;
        bus_soc_pkg::bus_data_t prev;
        bus_soc_pkg::bus_addr_t a;
        bus_soc_pkg::ls_type_e  t;
        int unsigned            ofs;
        rng              = 32'ha9a8_93ef;
        KEY0             = 1'b1;
        irq_src          = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = bus_soc_pkg::LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        #1 KEY0 = 1'b0;
        repeat (3) @(posedge CLOCK_50);
        @(negedge CLOCK_50) KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check("reset done flags", 64'd3, {bus_read_done, bus_write_done});
        check("reset interrupts", 64'd0, {meip, seip, mtip});

        // fill the window so every load has a known value
        for (int i = 0; i < WIN_BYTES / 8; i++) begin
            wd = {next_rand(), next_rand()};
            bus_access(1'b1, `RAM_BASE + 8 * i, wd, bus_soc_pkg::LS_D, rd);
            store_model(8 * i, wd, bus_soc_pkg::LS_D);
        end
        for (int n = 0; n < RAM_OPS; n++) begin
            ofs = next_rand() % WIN_BYTES;
            wd = {next_rand(), next_rand()};
            if (next_rand() & 1) begin
                t = bus_soc_pkg::ls_type_e'(3'(next_rand() % 4));
                bus_access(1'b1, `RAM_BASE + ofs, wd, t, rd);
                store_model(ofs, wd, t);
            end else begin
                t = bus_soc_pkg::ls_type_e'(3'(next_rand() % 7));
                bus_access(1'b0, `RAM_BASE + ofs, '0, t, rd);
                check($sformatf("ram load %s at %0d", t.name(), ofs), model_load(ofs, t), rd);
            end
        end

        // timer
        model_mtimecmp = {1'b1, 31'(next_rand()), next_rand()};
        bus_access(1'b1, `MTIMECMP_ADDR, model_mtimecmp, bus_soc_pkg::LS_D, rd);
        bus_access(1'b0, `MTIMECMP_ADDR, '0, bus_soc_pkg::LS_D, rd);
        check("mtimecmp readback", model_mtimecmp, rd);
        check("mtip with large mtimecmp", 64'd0, mtip);
        bus_access(1'b0, `MTIME_ADDR, '0, bus_soc_pkg::LS_D, prev);
        bus_access(1'b0, `MTIME_ADDR, '0, bus_soc_pkg::LS_D, rd);
        check("mtime increases", 64'd1, rd > prev);
        model_mtimecmp = 64'd16;
        bus_access(1'b1, `MTIMECMP_ADDR, model_mtimecmp, bus_soc_pkg::LS_D, rd);
        check("mtip after small mtimecmp", 64'd1, mtip);

        // plic registers, masked to their widths
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            wd = {next_rand(), next_rand()};
            bus_access(1'b1, `PLIC_BASE + 4 * i, wd, bus_soc_pkg::LS_W, rd);
            bus_access(1'b0, `PLIC_BASE + 4 * i, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("priority %0d", i), wd & ((64'd1 << `PLIC_PRIO_BITS) - 1), rd);
        end
        for (int c = 0; c < 2; c++) begin
            a = `PLIC_BASE + `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE;
            wd = {next_rand(), next_rand()};
            model_enable[c] = wd[31:0];
            bus_access(1'b1, a, wd, bus_soc_pkg::LS_W, rd);
            bus_access(1'b0, a, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("enable ctx %0d", c), {32'd0, model_enable[c]}, rd);
            a = `PLIC_BASE + `PLIC_THRESHOLD_OFS + c * `PLIC_CTX_STRIDE;
            wd = {next_rand(), next_rand()};
            bus_access(1'b1, a, wd, bus_soc_pkg::LS_W, rd);
            bus_access(1'b0, a, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("threshold ctx %0d", c), wd & ((64'd1 << `PLIC_PRIO_BITS) - 1), rd);
        end

        // source 1 routed to one context at a time
        model_pending = '0;
        for (int c = 0; c < 2; c++) begin
            for (int e = 0; e < 2; e++) begin
                model_enable[e] = (e == c) ? 32'h2 : 32'h0;
                a = `PLIC_BASE + `PLIC_ENABLE_OFS + e * `PLIC_ENABLE_STRIDE;
                bus_access(1'b1, a, {32'd0, model_enable[e]}, bus_soc_pkg::LS_W, rd);
            end
            @(negedge CLOCK_50) irq_src = 1'b1;
            @(negedge CLOCK_50) irq_src = 1'b0;
            model_pending[1] = 1'b1;
            bus_access(1'b0, `PLIC_BASE + `PLIC_PENDING_OFS, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("pending set ctx %0d", c), {32'd0, model_pending}, rd);
            check("meip level", model_enable[0][1] & model_pending[1], meip);
            check("seip level", model_enable[1][1] & model_pending[1], seip);
            a = `PLIC_BASE + `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE;
            bus_access(1'b0, a, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("first claim ctx %0d", c), 64'd1, rd);
            model_pending[1] = 1'b0;
            bus_access(1'b0, `PLIC_BASE + `PLIC_PENDING_OFS, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("pending cleared ctx %0d", c), {32'd0, model_pending}, rd);
            bus_access(1'b0, a, '0, bus_soc_pkg::LS_WU, rd);
            check($sformatf("second claim ctx %0d", c), 64'd0, rd);
            check("interrupts after claim", 64'd0, {meip, seip});
        end

        // nothing mapped here
        for (int i = 0; i < 4; i++) begin
            a = 64'h0000_0000_4000_0000 + (next_rand() & 32'h0000_fff8);
            bus_access(1'b1, a, {next_rand(), next_rand()}, bus_soc_pkg::LS_D, rd);
            bus_access(1'b0, a, '0, bus_soc_pkg::LS_D, rd);
            check($sformatf("unmapped read %h", a), 64'd0, rd);
        end

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 bus_soc_top_inst.bus_soc_chk_inst.fails);
        if (errors == 0 && bus_soc_top_inst.bus_soc_chk_inst.fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
